// ==== src/miner_pkg.sv ====
// Shared definitions for the nonce search engine
// Holds the register map, search sizing, SHA-256 constants and the
// bus and hash structs; design files refer to them by scoped name

`default_nettype none

package miner_pkg;

  typedef logic [31:0] word_t;

  // Register map
  localparam int    BLOCK_WORDS     = 20;
  localparam word_t BLOCK_BASE_ADDR = 32'h0000_0504;
  localparam word_t START_ADDR      = 32'h0000_0550;
  localparam word_t RESULT_ADDR     = 32'h0000_0554;
  localparam word_t READ_MISS_DATA  = 32'hFFFF_FFFF;

  // Search sizing
  localparam int NUM_LANES       = 2;
  localparam int DIFFICULTY_BITS = 8;
  localparam int SHA_ROUNDS      = 64;
  localparam int ROUND_W         = $clog2(SHA_ROUNDS);
  localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(SHA_ROUNDS - 1);

  // Message padding, marker bit then length in bits
  localparam word_t SHA_PAD_WORD    = 32'h8000_0000;
  localparam word_t HEADER_LEN_BITS = 32'd640;
  localparam word_t DIGEST_LEN_BITS = 32'd256;

  // ------------------------------------------------------------
  // AXI-Lite channel bundles
  // ------------------------------------------------------------
  typedef struct packed {
    logic  awvalid;
    word_t awaddr;
    logic  wvalid;
    word_t wdata;
    logic  bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic  arvalid;
    word_t araddr;
    logic  rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axil_rd_rsp_t;

  // ------------------------------------------------------------
  // Hash types, word 0 is the first big-endian message word
  // ------------------------------------------------------------
  typedef struct packed {
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    word_t g;
    word_t h;
  } sha_state_t;

  typedef word_t [0:15] sha_chunk_t;
  typedef word_t [0:BLOCK_WORDS-1] block_t;

  // Round constants
  localparam word_t SHA_K [SHA_ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash value
  localparam sha_state_t SHA_H_INIT = '{
    a: 32'h6a09e667, b: 32'hbb67ae85, c: 32'h3c6ef372, d: 32'ha54ff53a,
    e: 32'h510e527f, f: 32'h9b05688c, g: 32'h1f83d9ab, h: 32'h5be0cd19
  };

endpackage

`default_nettype wire

// ==== src/ocl_slave.sv ====
// Single-beat AXI-Lite slave for the miner register port
// Turns bus traffic into one-cycle write strobes and read requests;
// one write and one read may be open at a time

`default_nettype none

module ocl_slave (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  miner_pkg::axil_wr_req_t wr_req,
  output miner_pkg::axil_wr_rsp_t wr_rsp,
  input  miner_pkg::axil_rd_req_t rd_req,
  output miner_pkg::axil_rd_rsp_t rd_rsp,
  output logic                    wr_strobe,
  output miner_pkg::word_t        wr_addr,
  output miner_pkg::word_t        wr_data,
  output logic                    rd_strobe,
  output miner_pkg::word_t        rd_addr,
  input  miner_pkg::word_t        rd_data
);

  logic wr_open;
  logic bvalid;
  logic rvalid;
  logic aw_accept;
  logic b_accept;
  logic r_accept;

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  // Address taken only while no write is open
  assign aw_accept = wr_req.awvalid && !wr_open;
  // Single data beat, blocked once the response is up
  assign wr_strobe = wr_req.wvalid && wr_open && !bvalid;
  assign b_accept  = bvalid && wr_req.bready;
  assign wr_data   = wr_req.wdata;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_open <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // Write closes on the response handshake
      if (b_accept) begin
        wr_open <= 1'b0;
      end else if (aw_accept) begin
        wr_open <= 1'b1;
      end
      // Response follows the data beat by one cycle
      if (b_accept) begin
        bvalid <= 1'b0;
      end else if (wr_strobe) begin
        bvalid <= 1'b1;
      end
    end
  end

  // Captured write address
  always_ff @(posedge clk_main_a0) begin
    if (aw_accept) begin
      wr_addr <= wr_req.awaddr;
    end
  end

  assign wr_rsp.awready = !wr_open;
  assign wr_rsp.wready  = wr_strobe;
  assign wr_rsp.bvalid  = bvalid;
  assign wr_rsp.bresp   = 2'b00;

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  // Request goes out on the address handshake itself
  assign rd_strobe = rd_req.arvalid && !rvalid;
  assign rd_addr   = rd_req.araddr;
  assign r_accept  = rvalid && rd_req.rready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (r_accept) begin
      rvalid <= 1'b0;
    end else if (rd_strobe) begin
      rvalid <= 1'b1;
    end
  end

  // Read data register sits in block_regs and holds until the next request
  assign rd_rsp.arready = !rvalid;
  assign rd_rsp.rvalid  = rvalid;
  assign rd_rsp.rdata   = rd_data;
  assign rd_rsp.rresp   = 2'b00;

endmodule

`default_nettype wire

// ==== src/block_regs.sv ====
// Register file behind the AXI-Lite slave
// Holds the twenty header words, fires new_block on the last word,
// locks the first found nonce and answers register reads

`default_nettype none

module block_regs (
  input  logic                                          clk_main_a0,
  input  logic                                          rst_main_n_sync,
  input  logic                                          wr_strobe,
  input  miner_pkg::word_t                              wr_addr,
  input  miner_pkg::word_t                              wr_data,
  input  logic                                          rd_strobe,
  input  miner_pkg::word_t                              rd_addr,
  output miner_pkg::word_t                              rd_data,
  output miner_pkg::block_t                             block,
  output logic                                          new_block,
  output logic                                          halt,
  input  logic [miner_pkg::NUM_LANES-1:0]               found,
  input  miner_pkg::word_t [miner_pkg::NUM_LANES-1:0]   found_nonce
);

  miner_pkg::word_t wr_offset;
  miner_pkg::word_t result;
  miner_pkg::word_t first_nonce;
  logic             hdr_hit;

  // Word offset into the header window
  assign wr_offset = wr_addr - miner_pkg::BLOCK_BASE_ADDR;
  assign hdr_hit   = wr_strobe && (wr_offset[1:0] == 2'b00) &&
                     (wr_offset[31:2] < miner_pkg::BLOCK_WORDS);

  // Header words, 0x504 lands in word 0
  always_ff @(posedge clk_main_a0) begin
    for (int i = 0; i < miner_pkg::BLOCK_WORDS; i++) begin
      if (hdr_hit && (wr_offset[31:2] == i)) begin
        block[i] <= wr_data;
      end
    end
  end

  // Lowest lane index wins a same-cycle find
  always_comb begin
    first_nonce = found_nonce[0];
    for (int i = miner_pkg::NUM_LANES - 1; i >= 0; i--) begin
      if (found[i]) begin
        first_nonce = found_nonce[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Search control and result lock
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      new_block <= 1'b0;
      halt      <= 1'b0;
      result    <= '0;
    end else begin
      // Last word already stored when the pulse is seen
      new_block <= wr_strobe && (wr_addr == miner_pkg::START_ADDR);
      if (new_block) begin
        // Fresh search, stale finds dropped
        halt   <= 1'b0;
        result <= '0;
      end else if (!halt && (|found)) begin
        halt   <= 1'b1;
        result <= first_nonce;
      end
    end
  end

  // Read data, loaded on request and held through rvalid
  always_ff @(posedge clk_main_a0) begin
    if (rd_strobe) begin
      rd_data <= (rd_addr == miner_pkg::RESULT_ADDR) ? result : miner_pkg::READ_MISS_DATA;
    end
  end

endmodule

`default_nettype wire

// ==== src/sha256_core.sv ====
// Iterative SHA-256 compression of one 512-bit chunk
// One round per cycle from a rolling 16-word schedule; done pulses
// SHA_ROUNDS+1 cycles after start with digest valid in that cycle

`default_nettype none

module sha256_core (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  logic                  start,
  input  miner_pkg::sha_chunk_t chunk,
  input  miner_pkg::sha_state_t init,
  output logic                  done,
  output miner_pkg::sha_state_t digest
);

  logic                           busy;
  logic [miner_pkg::ROUND_W-1:0]  round_cnt;
  miner_pkg::sha_state_t          work;
  miner_pkg::sha_state_t          init_q;
  miner_pkg::sha_chunk_t          sched;
  miner_pkg::sha_state_t          next_work;
  miner_pkg::word_t               next_w;

  function automatic miner_pkg::word_t rotr(input miner_pkg::word_t x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // ------------------------------------------------------------
  // Round function and schedule extension
  // ------------------------------------------------------------
  always_comb begin : round_logic
    miner_pkg::word_t big_s0;
    miner_pkg::word_t big_s1;
    miner_pkg::word_t ch;
    miner_pkg::word_t maj;
    miner_pkg::word_t t1;
    miner_pkg::word_t t2;
    miner_pkg::word_t sml_s0;
    miner_pkg::word_t sml_s1;
    big_s1 = rotr(work.e, 6) ^ rotr(work.e, 11) ^ rotr(work.e, 25);
    ch     = (work.e & work.f) ^ (~work.e & work.g);
    // sched[0] is W[t] for the current round
    t1     = work.h + big_s1 + ch + miner_pkg::SHA_K[round_cnt] + sched[0];
    big_s0 = rotr(work.a, 2) ^ rotr(work.a, 13) ^ rotr(work.a, 22);
    maj    = (work.a & work.b) ^ (work.a & work.c) ^ (work.b & work.c);
    t2     = big_s0 + maj;
    next_work = '{
      a: t1 + t2, b: work.a, c: work.b, d: work.c,
      e: work.d + t1, f: work.e, g: work.f, h: work.g
    };
    // W[t+16] from the current window
    sml_s0 = rotr(sched[1], 7) ^ rotr(sched[1], 18) ^ (sched[1] >> 3);
    sml_s1 = rotr(sched[14], 17) ^ rotr(sched[14], 19) ^ (sched[14] >> 10);
    next_w = sml_s1 + sched[9] + sml_s0 + sched[0];
  end

  // ------------------------------------------------------------
  // Round sequencing
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      round_cnt <= '0;
    end else begin
      done <= 1'b0;
      // Start restarts even a busy core
      if (start) begin
        busy      <= 1'b1;
        round_cnt <= '0;
      end else if (busy) begin
        round_cnt <= round_cnt + 1'b1;
        if (round_cnt == miner_pkg::LAST_ROUND) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Working variables and schedule window
  always_ff @(posedge clk_main_a0) begin
    if (start) begin
      work   <= init;
      init_q <= init;
      sched  <= chunk;
    end else if (busy) begin
      work  <= next_work;
      sched <= {sched[1:15], next_w};
    end
  end

  // Feed-forward add, valid in the done cycle
  assign digest = '{
    a: work.a + init_q.a,
    b: work.b + init_q.b,
    c: work.c + init_q.c,
    d: work.d + init_q.d,
    e: work.e + init_q.e,
    f: work.f + init_q.f,
    g: work.g + init_q.g,
    h: work.h + init_q.h
  };

endmodule

`default_nettype wire

// ==== src/nonce_lane.sv ====
// One search lane of the miner
// Runs three compressions per nonce (header head, header tail with the
// nonce, then the digest), checks the target and steps by NUM_LANES

`default_nettype none

module nonce_lane #(
  // First nonce of this lane, below NUM_LANES
  parameter int unsigned LANE_INDEX = 0
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  miner_pkg::block_t block,
  input  logic              new_block,
  input  logic              halt,
  output logic              found,
  output miner_pkg::word_t  found_nonce
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START1,
    S_WAIT1,
    S_START2,
    S_WAIT2,
    S_START3,
    S_WAIT3
  } lane_state_t;

  lane_state_t           state;
  miner_pkg::word_t      nonce;
  miner_pkg::sha_state_t mid_state;
  miner_pkg::sha_state_t first_hash;
  logic                  core_start;
  miner_pkg::sha_chunk_t core_chunk;
  miner_pkg::sha_state_t core_init;
  logic                  core_done;
  miner_pkg::sha_state_t core_digest;
  logic                  hit;

  // Target test on the leading bits of H0
  assign hit = (core_digest.a[31 -: miner_pkg::DIFFICULTY_BITS] == '0);

  // ------------------------------------------------------------
  // Chunk and chaining value per compression
  // ------------------------------------------------------------
  always_comb begin
    core_start = 1'b0;
    core_chunk = block[0:15];
    core_init  = miner_pkg::SHA_H_INIT;
    case (state)
      S_START1: begin
        core_start = 1'b1;
      end
      S_START2: begin
        core_start = 1'b1;
        // Header tail, nonce in the last word, 640-bit length
        core_chunk = {block[16], block[17], block[18], nonce,
                      miner_pkg::SHA_PAD_WORD, {10{32'h0}}, miner_pkg::HEADER_LEN_BITS};
        core_init  = mid_state;
      end
      S_START3: begin
        core_start = 1'b1;
        // Second pass over the 256-bit digest
        core_chunk = {first_hash, miner_pkg::SHA_PAD_WORD, {6{32'h0}},
                      miner_pkg::DIGEST_LEN_BITS};
      end
      default: begin
      end
    endcase
  end

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state <= S_IDLE;
      found <= 1'b0;
    end else begin
      found <= 1'b0;
      if (new_block) begin
        state <= S_START1;
      end else if (halt) begin
        state <= S_IDLE;
      end else begin
        case (state)
          S_START1: state <= S_WAIT1;
          S_WAIT1:  state <= core_done ? S_START2 : S_WAIT1;
          S_START2: state <= S_WAIT2;
          S_WAIT2:  state <= core_done ? S_START3 : S_WAIT2;
          S_START3: state <= S_WAIT3;
          S_WAIT3: begin
            if (core_done) begin
              found <= hit;
              state <= S_START1;
            end
          end
          default:  state <= S_IDLE;
        endcase
      end
    end
  end

  // Nonce stepping and intermediate hashes
  always_ff @(posedge clk_main_a0) begin
    if (new_block) begin
      nonce <= miner_pkg::word_t'(LANE_INDEX);
    end else if ((state == S_WAIT3) && core_done) begin
      nonce <= nonce + miner_pkg::word_t'(miner_pkg::NUM_LANES);
    end
    if ((state == S_WAIT1) && core_done) begin
      mid_state <= core_digest;
    end
    if ((state == S_WAIT2) && core_done) begin
      first_hash <= core_digest;
    end
    if ((state == S_WAIT3) && core_done && hit) begin
      found_nonce <= nonce;
    end
  end

  sha256_core u_core (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .start           (core_start),
    .chunk           (core_chunk),
    .init            (core_init),
    .done            (core_done),
    .digest          (core_digest)
  );

endmodule

`default_nettype wire

// ==== src/miner_top.sv ====
// Top level of the nonce search engine
// AXI-Lite slave, register file and the search lanes; lane k starts
// at nonce k and all lanes run in lockstep

`default_nettype none

module miner_top (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  miner_pkg::axil_wr_req_t wr_req,
  output miner_pkg::axil_wr_rsp_t wr_rsp,
  input  miner_pkg::axil_rd_req_t rd_req,
  output miner_pkg::axil_rd_rsp_t rd_rsp
);

  // Register access
  logic              wr_strobe;
  miner_pkg::word_t  wr_addr;
  miner_pkg::word_t  wr_data;
  logic              rd_strobe;
  miner_pkg::word_t  rd_addr;
  miner_pkg::word_t  rd_data;

  // Search control
  miner_pkg::block_t block;
  logic              new_block;
  logic              halt;
  logic [miner_pkg::NUM_LANES-1:0]             found;
  miner_pkg::word_t [miner_pkg::NUM_LANES-1:0] found_nonce;

  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_req          (wr_req),
    .wr_rsp          (wr_rsp),
    .rd_req          (rd_req),
    .rd_rsp          (rd_rsp),
    .wr_strobe       (wr_strobe),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_strobe       (rd_strobe),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  block_regs u_block_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_strobe       (wr_strobe),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_strobe       (rd_strobe),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .block           (block),
    .new_block       (new_block),
    .halt            (halt),
    .found           (found),
    .found_nonce     (found_nonce)
  );

  // One lane per nonce residue
  for (genvar i = 0; i < miner_pkg::NUM_LANES; i++) begin : g_lane
    nonce_lane #(
      .LANE_INDEX (i)
    ) u_lane (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .block           (block),
      .new_block       (new_block),
      .halt            (halt),
      .found           (found[i]),
      .found_nonce     (found_nonce[i])
    );
  end

endmodule

`default_nettype wire

// ==== verif/miner_props.sv ====
// AXI-Lite protocol assertions for the miner register port
// Bound into ocl_slave; each failure bumps fail_count for the testbench

`default_nettype none

module miner_props (
  input logic                    clk_main_a0,
  input logic                    rst_main_n_sync,
  input miner_pkg::axil_wr_req_t wr_req,
  input miner_pkg::axil_wr_rsp_t wr_rsp,
  input miner_pkg::axil_rd_req_t rd_req,
  input miner_pkg::axil_rd_rsp_t rd_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic bus_wr_open;

  // Write open from the address handshake to the response handshake
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bus_wr_open <= 1'b0;
    end else if (wr_rsp.bvalid && wr_req.bready) begin
      bus_wr_open <= 1'b0;
    end else if (wr_req.awvalid && wr_rsp.awready) begin
      bus_wr_open <= 1'b1;
    end
  end

  // Write response held until bready
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  // Read data held with rvalid until rready
  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.rdata))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before rready");
    end

  // No second address while a write is open
  aw_blocked: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bus_wr_open |-> !wr_rsp.awready)
    else begin
      fail_count++;
      $error("awready high during an open write");
    end

  // Responses are always OKAY
  resp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (wr_rsp.bresp == 2'b00) && (rd_rsp.rresp == 2'b00))
    else begin
      fail_count++;
      $error("non-zero bresp or rresp");
    end

endmodule

bind ocl_slave miner_props u_props (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .wr_req          (wr_req),
  .wr_rsp          (wr_rsp),
  .rd_req          (rd_req),
  .rd_rsp          (rd_rsp)
);

`default_nettype wire

// ==== verif/miner_model.svh ====
// Reference SHA-256 and nonce search for the miner testbench
// Included inside the testbench module; the header word 0 is the
// first big-endian message word and the nonce replaces word 19

`ifndef MINER_MODEL_SVH
`define MINER_MODEL_SVH

typedef logic [0:7][31:0]  hash_words_t;
typedef logic [0:15][31:0] msg_words_t;
typedef logic [0:19][31:0] header_words_t;

// FIPS 180-2 initial hash value
localparam hash_words_t IV_WORDS = {
  32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
  32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};
localparam int          NONCE_SEARCH_LIMIT = 65536;
localparam logic [31:0] NO_NONCE           = 32'hFFFF_FFFF;

function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
  return (x >> n) | (x << (32 - n));
endfunction

// One compression, full 64-word schedule up front
function automatic hash_words_t compress_chunk(input hash_words_t iv, input msg_words_t m);
  logic [31:0] w [64];
  logic [31:0] v [8];
  logic [31:0] s0;
  logic [31:0] s1;
  logic [31:0] t1;
  logic [31:0] t2;
  hash_words_t res;
  for (int t = 0; t < 64; t++) begin
    if (t < 16) begin
      w[t] = m[t];
    end else begin
      s0 = rotr32(w[t-15], 7) ^ rotr32(w[t-15], 18) ^ (w[t-15] >> 3);
      s1 = rotr32(w[t-2], 17) ^ rotr32(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
  end
  for (int i = 0; i < 8; i++) begin
    v[i] = iv[i];
  end
  for (int t = 0; t < 64; t++) begin
    s1 = rotr32(v[4], 6) ^ rotr32(v[4], 11) ^ rotr32(v[4], 25);
    t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + miner_pkg::SHA_K[t] + w[t];
    s0 = rotr32(v[0], 2) ^ rotr32(v[0], 13) ^ rotr32(v[0], 22);
    t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
    // Shift a..h down one place, then patch e and a
    for (int i = 7; i > 0; i--) begin
      v[i] = v[i-1];
    end
    v[4] = v[4] + t1;
    v[0] = t1 + t2;
  end
  for (int i = 0; i < 8; i++) begin
    res[i] = iv[i] + v[i];
  end
  return res;
endfunction

// H0 of the double hash for one nonce
function automatic logic [31:0] pow_h0(input header_words_t hdr, input logic [31:0] nonce);
  hash_words_t mid;
  hash_words_t first;
  hash_words_t second;
  mid    = compress_chunk(IV_WORDS, hdr[0:15]);
  first  = compress_chunk(mid, {hdr[16], hdr[17], hdr[18], nonce,
                                32'h8000_0000, {10{32'h0}}, 32'd640});
  second = compress_chunk(IV_WORDS, {first, 32'h8000_0000, {6{32'h0}}, 32'd256});
  return second[0];
endfunction

// Lanes run in lockstep and lane 0 wins a tie, so the smallest nonce wins
function automatic logic [31:0] smallest_nonce(input header_words_t hdr);
  logic [31:0] h0;
  for (int n = 0; n < NONCE_SEARCH_LIMIT; n++) begin
    h0 = pow_h0(hdr, 32'(n));
    if (h0[31 -: miner_pkg::DIFFICULTY_BITS] == '0) begin
      return 32'(n);
    end
  end
  return NO_NONCE;
endfunction

`endif

// ==== verif/miner_tb.sv ====
// Testbench for the nonce search engine
// Loads LCG headers over AXI-Lite, polls the result register and
// compares it with the reference search from miner_model.svh

`default_nettype none

module miner_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LCG_SEED   = 41408;
  localparam int          WAIT_LIMIT = 50;
  // Nonce 0 reads like an unlocked result, so stop polling after this
  localparam int          ZERO_POLLS = 150;
  localparam int          HOLD_READS = 20;

  logic                    clk_main_a0;
  logic                    rst_main_n_sync;
  miner_pkg::axil_wr_req_t wr_req;
  miner_pkg::axil_wr_rsp_t wr_rsp;
  miner_pkg::axil_rd_req_t rd_req;
  miner_pkg::axil_rd_rsp_t rd_rsp;
  int unsigned             lcg_state;

  `include "miner_model.svh"

  miner_top dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_req          (wr_req),
    .wr_rsp          (wr_rsp),
    .rd_req          (rd_req),
    .rd_rsp          (rd_rsp)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #4 clk_main_a0 = ~clk_main_a0;
  end

  // ------------------------------------------------------------
  // Stimulus and checking helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic header_words_t random_header();
    header_words_t hdr;
    for (int i = 0; i < miner_pkg::BLOCK_WORDS; i++) begin
      hdr[i] = next_rand();
    end
    return hdr;
  endfunction

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      report_fail($sformatf("[FAIL] %0d ns: %s, got %08h expected %08h",
                            $time, what, actual, expected));
    end
  endtask

  // Watch the bound protocol checks
  always @(posedge clk_main_a0) begin
    if (dut.u_ocl_slave.u_props.fail_count != 0) begin
      report_fail("A bus protocol assertion failed");
    end
  end

  // Handshake signals sampled just after the edge hold their pre-edge values
  task automatic bus_write(input miner_pkg::word_t addr, input miner_pkg::word_t data);
    int cycles;
    wr_req.awvalid <= 1'b1;
    wr_req.awaddr  <= addr;
    cycles = 0;
    do begin
      @(posedge clk_main_a0);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("Timeout: write address was never accepted");
    end while (!wr_rsp.awready);
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b1;
    wr_req.wdata   <= data;
    cycles = 0;
    do begin
      @(posedge clk_main_a0);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("Timeout: write data was never accepted");
    end while (!wr_rsp.wready);
    wr_req.wvalid <= 1'b0;
    wr_req.bready <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_main_a0);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("Timeout: write response never arrived");
    end while (!wr_rsp.bvalid);
    wr_req.bready <= 1'b0;
    check_eq(32'(wr_rsp.bresp), 32'h0, "bresp of a write");
  endtask

  task automatic bus_read(input miner_pkg::word_t addr, output miner_pkg::word_t data);
    int cycles;
    rd_req.arvalid <= 1'b1;
    rd_req.araddr  <= addr;
    cycles = 0;
    do begin
      @(posedge clk_main_a0);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("Timeout: read address was never accepted");
    end while (!rd_rsp.arready);
    rd_req.arvalid <= 1'b0;
    rd_req.rready  <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_main_a0);
      cycles++;
      if (cycles > WAIT_LIMIT) report_fail("Timeout: read data never arrived");
    end while (!rd_rsp.rvalid);
    rd_req.rready <= 1'b0;
    data = rd_rsp.rdata;
    check_eq(32'(rd_rsp.rresp), 32'h0, "rresp of a read");
  endtask

  task automatic read_unmapped();
    miner_pkg::word_t addr;
    miner_pkg::word_t data;
    addr = next_rand();
    if (addr == miner_pkg::RESULT_ADDR) addr = addr ^ 32'h10;
    bus_read(addr, data);
    check_eq(data, miner_pkg::READ_MISS_DATA, $sformatf("read of unmapped %08h", addr));
  endtask

  // Word 19 lands on START_ADDR, which kicks off the search
  task automatic load_header(input header_words_t hdr, input bit mixed_reads);
    for (int i = 0; i < miner_pkg::BLOCK_WORDS; i++) begin
      bus_write(miner_pkg::BLOCK_BASE_ADDR + 32'(4 * i), hdr[i]);
      if (mixed_reads && (i % 4 == 1)) read_unmapped();
    end
  endtask

  task automatic search_and_check(input header_words_t hdr, input bit mixed_reads);
    miner_pkg::word_t expected;
    miner_pkg::word_t data;
    int               polls;
    int               limit;
    expected = smallest_nonce(hdr);
    if (expected == NO_NONCE) report_fail("Model found no qualifying nonce for the header");
    load_header(hdr, mixed_reads);
    // About 200 cycles per lane step, two cycles per poll
    limit = (int'(expected >> 1) + 4) * 200;
    polls = 0;
    data  = '0;
    while ((data == '0) && !((expected == '0) && (polls >= ZERO_POLLS))) begin
      if (polls >= limit) report_fail("Timeout: result register never locked");
      bus_read(miner_pkg::RESULT_ADDR, data);
      polls++;
    end
    check_eq(data, expected, "first nonzero result of the search");
    // Lock holds until the next block
    repeat (HOLD_READS) begin
      bus_read(miner_pkg::RESULT_ADDR, data);
      check_eq(data, expected, "result after lock");
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    header_words_t    hdr;
    hash_words_t      kat;
    miner_pkg::word_t data;
    wr_req          = '0;
    rd_req          = '0;
    rst_main_n_sync = 1'b0;
    lcg_state       = LCG_SEED;
    // Model sanity on the FIPS 180-2 "abc" vector
    kat = compress_chunk(IV_WORDS, {32'h6162_6380, {14{32'h0}}, 32'h18});
    check_eq(kat[0], 32'hba7816bf, "model digest word 0 for abc");
    check_eq(kat[7], 32'hf20015ad, "model digest word 7 for abc");
    repeat (5) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(posedge clk_main_a0);
    bus_read(miner_pkg::RESULT_ADDR, data);
    check_eq(data, 32'h0, "result after reset");
    repeat (4) read_unmapped();
    // Plain search, reads mixed into the load
    search_and_check(random_header(), 1'b1);
    // Start a search, then replace it early
    hdr = random_header();
    load_header(hdr, 1'b0);
    // Three compressions take longer than these polls
    repeat (30) begin
      bus_read(miner_pkg::RESULT_ADDR, data);
      check_eq(data, 32'h0, "result early in a search");
    end
    search_and_check(random_header(), 1'b1);
    search_and_check(random_header(), 1'b0);
    if (dut.u_ocl_slave.u_props.fail_count != 0) begin
      $display("%0d bus protocol assertions failed", dut.u_ocl_slave.u_props.fail_count);
      $display("Test failed");
      $fatal(1, "protocol assertions failed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verif
src/miner_pkg.sv
src/ocl_slave.sv
src/block_regs.sv
src/sha256_core.sv
src/nonce_lane.sv
src/miner_top.sv
verif/miner_props.sv
verif/miner_tb.sv

// ==== Bender.yml ====
package:
  name: nonce_miner

sources:
  - files:
      - src/miner_pkg.sv
      - src/ocl_slave.sv
      - src/block_regs.sv
      - src/sha256_core.sv
      - src/nonce_lane.sv
      - src/miner_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/miner_props.sv
      - verif/miner_tb.sv
